/* all.f */
src/tcb_pkg.sv
src/soc_map_pkg.sv
src/tcb_demux.sv
src/tcb_sram_sub.sv
src/tcb_reg_sub.sv
src/tcb_subsys.sv
verif/tcb_subsys_tb.sv

/* Makefile */
VERILATOR = verilator
FLAGS     = --timing --assert
TOP       = tcb_subsys_tb
FILELIST  = all.f
LOG       = sim.log
FAIL_MSG  = TEST RESULT: FAIL
PASS_MSG  = TEST RESULT: PASS

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

# the run status is ignored, the log decides
sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	-./obj_dir/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation ended without a result"; exit 1)

clean:
	rm -rf obj_dir $(LOG)

/* verif/tcb_subsys_tb.sv */
// testbench for the bus subsystem with DLY 2 and 1024 SRAM words
// a reference model predicts each response and assertions check cycle and contents
// stops at the first error

module tcb_subsys_tb;

  localparam int unsigned DLY       = 2;
  localparam int unsigned MEM_WORDS = 1024;
  // cycles allowed for rdy or for the last responses
  localparam int unsigned TIMEOUT   = 50;

  // expected response and the cycle it is due in
  typedef struct packed {
    int unsigned             cyc;
    logic [tcb_pkg::DBW-1:0] rdt;
    logic                    err;
  } exp_t;

  logic              tcb;
  logic              reset;
  tcb_pkg::tcb_req_t req;
  logic              rdy;
  tcb_pkg::tcb_rsp_t rsp;

  integer                  seed;
  logic [31:0]             rnd;
  int unsigned             cyc;
  int unsigned             waited;
  exp_t                    exp_q [$];
  exp_t                    due;
  exp_t                    fresh;
  logic                    reg_prev;
  // reference model state
  logic [tcb_pkg::DBW-1:0] mem_model [MEM_WORDS];
  logic [tcb_pkg::DBW-1:0] scratch_model;
  logic [tcb_pkg::DBW-1:0] count_model;

  tcb_subsys #(
    .DLY       (DLY),
    .MEM_WORDS (MEM_WORDS)
  ) dut (
    .tcb   (tcb),
    .reset (reset),
    .req   (req),
    .rdy   (rdy),
    .rsp   (rsp)
  );

  always #2 tcb = ~tcb;

  //////////////////////////////
  // helpers
  //////////////////////////////

  task automatic abort_run(input string line);
    $display("%s", line);
    $display("TEST RESULT: FAIL");
    $fatal(1, "simulation stopped at first error");
  endtask

  // window match on the address map
  function automatic logic [1:0] target_of(input logic [tcb_pkg::ABW-1:0] adr);
    if ((adr & soc_map_pkg::SRAM_MASK) == soc_map_pkg::SRAM_BASE) begin
      return soc_map_pkg::SUB_SRAM;
    end else if ((adr & soc_map_pkg::REG_MASK) == soc_map_pkg::REG_BASE) begin
      return soc_map_pkg::SUB_REG;
    end
    return soc_map_pkg::SUB_NONE;
  endfunction

  // bytes with ben set take the new value
  function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] nxt,
                                              input logic [3:0] ben);
    logic [31:0] res;
    res = old;
    for (int b = 0; b < 4; b++) begin
      if (ben[b]) begin
        res[8*b +: 8] = nxt[8*b +: 8];
      end
    end
    return res;
  endfunction

  // stride of 37 words spreads the accesses over the array
  function automatic logic [tcb_pkg::ABW-1:0] sram_adr(input int unsigned i);
    logic [31:0] w;
    w = (i * 37) % MEM_WORDS;
    return soc_map_pkg::SRAM_BASE + (w << 2);
  endfunction

  // expected response of one transfer with model update
  task automatic model_transfer(input tcb_pkg::tcb_req_t r, output logic [31:0] rdt,
                                output logic err);
    logic [31:0] ofs;
    rdt = '0;
    err = 1'b0;
    ofs = r.adr & ~soc_map_pkg::REG_MASK;
    case (target_of(r.adr))
      soc_map_pkg::SUB_SRAM: begin
        if (r.wen) begin
          mem_model[r.adr[11:2]] = merge_bytes(mem_model[r.adr[11:2]], r.wdt, r.ben);
        end else begin
          rdt = mem_model[r.adr[11:2]];
        end
      end
      soc_map_pkg::SUB_REG: begin
        case (ofs)
          soc_map_pkg::REG_ID:      err = r.wen;
          soc_map_pkg::REG_SCRATCH: begin
            if (r.wen) begin
              scratch_model = merge_bytes(scratch_model, r.wdt, r.ben);
            end
          end
          soc_map_pkg::REG_COUNT:   err = r.wen;
          default:                  err = 1'b1;
        endcase
        if (!r.wen && ofs == soc_map_pkg::REG_ID) rdt = soc_map_pkg::ID_VALUE;
        if (!r.wen && ofs == soc_map_pkg::REG_SCRATCH) rdt = scratch_model;
        // count seen before this transfer
        if (!r.wen && ofs == soc_map_pkg::REG_COUNT) rdt = count_model;
        count_model = count_model + 1;
      end
      default: err = 1'b1;
    endcase
  endtask

  // drive one request and hold it until accepted
  task automatic issue(input logic wen, input logic [31:0] adr, input logic [3:0] ben,
                       input logic [31:0] wdt);
    tcb_pkg::tcb_req_t r;
    r     = '0;
    r.vld = 1'b1;
    r.wen = wen;
    r.adr = adr;
    r.ben = ben;
    r.wdt = wdt;
    req <= r;
    waited = 0;
    @(posedge tcb);
    while (!rdy) begin
      waited++;
      if (waited > TIMEOUT) begin
        abort_run($sformatf("request to address %h was never accepted", adr));
      end
      @(posedge tcb);
    end
  endtask

  task automatic idle(input int unsigned n);
    req.vld <= 1'b0;
    repeat (n) @(posedge tcb);
  endtask

  //////////////////////////////
  // monitor and checks
  //////////////////////////////

  always @(posedge tcb) begin
    if (reset) begin
      // state is unknown before the first reset edge
      if (cyc != 0) begin
        assert (!rsp.vld)
          else abort_run($sformatf("CHECK FAILED time %0t: rsp.vld in reset", $time));
      end
      reg_prev = 1'b0;
    end else begin
      if (exp_q.size() != 0 && exp_q[0].cyc == cyc) begin
        assert (rsp.vld) else abort_run($sformatf("CHECK FAILED time %0t: response missing", $time));
      end
      if (rsp.vld) begin
        assert (exp_q.size() != 0)
          else abort_run($sformatf("CHECK FAILED time %0t: response without transfer", $time));
        due = exp_q.pop_front();
        assert (due.cyc == cyc) else abort_run($sformatf(
          "CHECK FAILED time %0t: response in cycle %0d, due in %0d", $time, cyc, due.cyc));
        assert (rsp.rdt == due.rdt) else abort_run($sformatf(
          "CHECK FAILED time %0t: rdt %h, expected %h", $time, rsp.rdt, due.rdt));
        assert (rsp.err == due.err) else abort_run($sformatf(
          "CHECK FAILED time %0t: err %b, expected %b", $time, rsp.err, due.err));
      end
      // register block stalls exactly one cycle and the rest never stall
      if (req.vld) begin
        if (target_of(req.adr) == soc_map_pkg::SUB_REG) begin
          assert (rdy == !reg_prev)
            else abort_run($sformatf("CHECK FAILED time %0t: register rdy %b", $time, rdy));
        end else begin
          assert (rdy) else abort_run($sformatf("CHECK FAILED time %0t: rdy low", $time));
        end
      end
      reg_prev = req.vld & rdy & (target_of(req.adr) == soc_map_pkg::SUB_REG);
      if (req.vld && rdy) begin
        model_transfer(req, fresh.rdt, fresh.err);
        fresh.cyc = cyc + DLY;
        exp_q.push_back(fresh);
      end
    end
    cyc++;
  end

  //////////////////////////////
  // stimulus
  //////////////////////////////

  initial begin
    tcb           = 1'b0;
    reset         = 1'b1;
    req           = '0;
    seed          = 91739;
    cyc           = 0;
    reg_prev      = 1'b0;
    scratch_model = '0;
    count_model   = '0;
    repeat (16) @(posedge tcb);
    reset <= 1'b0;
    idle(4);
    // back to back sram fill, partial writes and read back
    for (int i = 0; i < 8; i++) begin
      issue(1'b1, sram_adr(i), 4'hf, $random(seed));
    end
    for (int i = 0; i < 8; i++) begin
      rnd = $random(seed);
      issue(1'b1, sram_adr(i), rnd[3:0], $random(seed));
    end
    for (int i = 0; i < 8; i++) begin
      issue(1'b0, sram_adr(i), 4'hf, '0);
    end
    idle(4);
    // each back to back register request meets the stall
    issue(1'b0, soc_map_pkg::REG_BASE + soc_map_pkg::REG_ID, 4'hf, '0);
    issue(1'b1, soc_map_pkg::REG_BASE + soc_map_pkg::REG_SCRATCH, 4'hf, 32'h1234_5678);
    issue(1'b1, soc_map_pkg::REG_BASE + soc_map_pkg::REG_SCRATCH, 4'b0101, 32'haabb_ccdd);
    issue(1'b0, soc_map_pkg::REG_BASE + soc_map_pkg::REG_SCRATCH, 4'hf, '0);
    issue(1'b1, soc_map_pkg::REG_BASE + soc_map_pkg::REG_ID, 4'hf, 32'hdead_beef);
    issue(1'b0, soc_map_pkg::REG_BASE + soc_map_pkg::REG_ID, 4'hf, '0);
    issue(1'b1, soc_map_pkg::REG_BASE + soc_map_pkg::REG_COUNT, 4'hf, 32'h0000_0077);
    issue(1'b0, soc_map_pkg::REG_BASE + soc_map_pkg::REG_COUNT, 4'hf, '0);
    issue(1'b0, soc_map_pkg::REG_BASE + 32'h0000_000c, 4'hf, '0);
    idle(4);
    // unmapped accesses mixed into sram and register traffic
    issue(1'b0, sram_adr(3), 4'hf, '0);
    issue(1'b1, 32'h2000_0000, 4'hf, 32'h0bad_0bad);
    issue(1'b0, sram_adr(5), 4'hf, '0);
    issue(1'b0, 32'h0004_0010, 4'hf, '0);
    issue(1'b1, sram_adr(5), 4'b0011, $random(seed));
    issue(1'b0, soc_map_pkg::REG_BASE + soc_map_pkg::REG_COUNT, 4'hf, '0);
    issue(1'b0, sram_adr(5), 4'hf, '0);
    idle(1);
    waited = 0;
    while (exp_q.size() != 0) begin
      if (waited > TIMEOUT) begin
        abort_run("outstanding responses never arrived");
      end
      waited++;
      @(posedge tcb);
    end
    // quiet tail catches responses without a transfer
    idle(8);
    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule : tcb_subsys_tb

/* src/tcb_subsys.sv */
// bus subsystem, one manager port, SRAM and register block behind a demux
// end-to-end response delay is DLY cycles, DLY at least 1

module tcb_subsys #(
  parameter int unsigned DLY       = 2,
  parameter int unsigned MEM_WORDS = 1024
) (
  input  logic              tcb,
  input  logic              reset,
  input  tcb_pkg::tcb_req_t req,
  output logic              rdy,
  output tcb_pkg::tcb_rsp_t rsp
);

  // demux to subordinates
  tcb_pkg::tcb_req_t sram_req;
  tcb_pkg::tcb_req_t reg_req;
  logic              sram_rdy;
  logic              reg_rdy;
  tcb_pkg::tcb_rsp_t sram_rsp;
  tcb_pkg::tcb_rsp_t reg_rsp;

  // address decode and response merge
  tcb_demux #(
    .DLY (DLY)
  ) u_demux (
    .tcb      (tcb),
    .reset    (reset),
    .req      (req),
    .rdy      (rdy),
    .rsp      (rsp),
    .sram_req (sram_req),
    .sram_rdy (sram_rdy),
    .sram_rsp (sram_rsp),
    .reg_req  (reg_req),
    .reg_rdy  (reg_rdy),
    .reg_rsp  (reg_rsp)
  );

  // memory
  tcb_sram_sub #(
    .DLY       (DLY),
    .MEM_WORDS (MEM_WORDS)
  ) u_sram (
    .tcb   (tcb),
    .reset (reset),
    .req   (sram_req),
    .rdy   (sram_rdy),
    .rsp   (sram_rsp)
  );

  // control registers
  tcb_reg_sub #(
    .DLY (DLY)
  ) u_reg (
    .tcb   (tcb),
    .reset (reset),
    .req   (reg_req),
    .rdy   (reg_rdy),
    .rsp   (reg_rsp)
  );

endmodule : tcb_subsys

/* src/tcb_reg_sub.sv */
// register subordinate with id, scratch and transfer count
// rdy drops for one cycle after every transfer, so at most half throughput
// writes to read-only or unknown offsets return err, DLY at least 1

module tcb_reg_sub #(
  parameter int unsigned DLY = 2
) (
  input  logic              tcb,
  input  logic              reset,
  input  tcb_pkg::tcb_req_t req,
  output logic              rdy,
  output tcb_pkg::tcb_rsp_t rsp
);

  logic                    trn;
  logic                    stall;
  logic [tcb_pkg::ABW-1:0] ofs;
  logic [tcb_pkg::DBW-1:0] scratch;
  logic [tcb_pkg::DBW-1:0] count;
  logic [tcb_pkg::DBW-1:0] rd_val;
  logic                    rd_err;
  logic                    wr_scratch;
  tcb_pkg::tcb_rsp_t       pip [DLY];

  //////////////////////////////
  // handshake
  //////////////////////////////

  // ready from own state only
  assign rdy = ~stall;
  assign trn = req.vld & rdy;

  // one idle cycle after each accepted transfer
  always_ff @(posedge tcb) begin
    if (reset) begin
      stall <= 1'b0;
    end else begin
      stall <= trn;
    end
  end

  //////////////////////////////
  // decode
  //////////////////////////////

  // byte offset inside the window
  assign ofs = req.adr & ~soc_map_pkg::REG_MASK;

  always_comb begin
    rd_val = '0;
    rd_err = 1'b1;
    case (ofs)
      soc_map_pkg::REG_ID: begin
        rd_val = soc_map_pkg::ID_VALUE;
        rd_err = req.wen;
      end
      soc_map_pkg::REG_SCRATCH: begin
        rd_val = scratch;
        rd_err = 1'b0;
      end
      // count before this transfer
      soc_map_pkg::REG_COUNT: begin
        rd_val = count;
        rd_err = req.wen;
      end
      default: begin
        rd_val = '0;
        rd_err = 1'b1;
      end
    endcase
  end

  assign wr_scratch = trn & req.wen & (ofs == soc_map_pkg::REG_SCRATCH);

  //////////////////////////////
  // registers
  //////////////////////////////

  always_ff @(posedge tcb) begin
    if (reset) begin
      scratch <= '0;
      count   <= '0;
    end else begin
      for (int b = 0; b < tcb_pkg::BEW; b++) begin
        if (wr_scratch & req.ben[b]) begin
          scratch[8*b +: 8] <= req.wdt[8*b +: 8];
        end
      end
      // every accepted transfer counts, errors too
      if (trn) begin
        count <= count + 1'b1;
      end
    end
  end

  //////////////////////////////
  // response pipeline
  //////////////////////////////

  always_ff @(posedge tcb) begin
    if (reset) begin
      for (int i = 0; i < DLY; i++) begin
        pip[i].vld <= 1'b0;
      end
    end else begin
      pip[0].vld <= trn;
      for (int i = 1; i < DLY; i++) begin
        pip[i].vld <= pip[i-1].vld;
      end
    end
    // write responses carry zero data
    pip[0].rdt <= req.wen ? '0 : rd_val;
    pip[0].err <= rd_err;
    for (int i = 1; i < DLY; i++) begin
      pip[i].rdt <= pip[i-1].rdt;
      pip[i].err <= pip[i-1].err;
    end
  end

  assign rsp = pip[DLY-1];

endmodule : tcb_reg_sub

/* src/tcb_sram_sub.sv */
// byte-enabled SRAM subordinate, never stalls
// MEM_WORDS must be a power of two and at least 2, DLY at least 1
// address bits above the memory depth are ignored, no alignment check

module tcb_sram_sub #(
  parameter int unsigned DLY       = 2,
  parameter int unsigned MEM_WORDS = 1024
) (
  input  logic              tcb,
  input  logic              reset,
  input  tcb_pkg::tcb_req_t req,
  output logic              rdy,
  output tcb_pkg::tcb_rsp_t rsp
);

  // word index width
  localparam int unsigned AW = $clog2(MEM_WORDS);

  // one response pipeline stage
  typedef struct packed {
    logic                    vld;
    logic                    wen;
    logic [tcb_pkg::DBW-1:0] rdt;
  } stg_t;

  logic [tcb_pkg::DBW-1:0] mem [MEM_WORDS];
  logic [AW-1:0]           idx;
  logic                    trn;
  stg_t                    pip [DLY];

  assign rdy = 1'b1;
  assign trn = req.vld & rdy;

  // word address, byte offset bits dropped
  assign idx = req.adr[AW+1:2];

  //////////////////////////////
  // memory write
  //////////////////////////////

  // only bytes with ben set are updated
  always_ff @(posedge tcb) begin
    for (int b = 0; b < tcb_pkg::BEW; b++) begin
      if (trn & req.wen & req.ben[b]) begin
        mem[idx][8*b +: 8] <= req.wdt[8*b +: 8];
      end
    end
  end

  //////////////////////////////
  // response pipeline
  //////////////////////////////

  always_ff @(posedge tcb) begin
    // valid strobes
    if (reset) begin
      for (int i = 0; i < DLY; i++) begin
        pip[i].vld <= 1'b0;
      end
    end else begin
      pip[0].vld <= trn;
      for (int i = 1; i < DLY; i++) begin
        pip[i].vld <= pip[i-1].vld;
      end
    end
    // stage 0 loads only on a transfer
    if (trn) begin
      pip[0].wen <= req.wen;
    end
    if (trn & ~req.wen) begin
      pip[0].rdt <= mem[idx];
    end
    for (int i = 1; i < DLY; i++) begin
      pip[i].wen <= pip[i-1].wen;
      pip[i].rdt <= pip[i-1].rdt;
    end
  end

  // writes return zero data
  always_comb begin
    rsp.vld = pip[DLY-1].vld;
    rsp.rdt = pip[DLY-1].wen ? '0 : pip[DLY-1].rdt;
    rsp.err = 1'b0;
  end

endmodule : tcb_sram_sub

/* src/tcb_demux.sv */
// one manager to two subordinates, decoded on the address map
// DLY must match the response delay of both subordinates, at least 1
// unmapped accesses are accepted at once and answered with err

module tcb_demux #(
  parameter int unsigned DLY = 2
) (
  input  logic              tcb,
  input  logic              reset,
  // manager side
  input  tcb_pkg::tcb_req_t req,
  output logic              rdy,
  output tcb_pkg::tcb_rsp_t rsp,
  // sram side
  output tcb_pkg::tcb_req_t sram_req,
  input  logic              sram_rdy,
  input  tcb_pkg::tcb_rsp_t sram_rsp,
  // register side
  output tcb_pkg::tcb_req_t reg_req,
  input  logic              reg_rdy,
  input  tcb_pkg::tcb_rsp_t reg_rsp
);

  // one entry of the select pipeline
  typedef struct packed {
    logic [1:0] sel;
    // unmapped transfer, this entry answers itself
    logic       nxe;
  } sel_t;

  logic [1:0] sel;
  logic       trn;
  sel_t       sel_pip [DLY];
  sel_t       sel_out;

  //////////////////////////////
  // decode and routing
  //////////////////////////////

  always_comb begin
    if ((req.adr & soc_map_pkg::SRAM_MASK) == soc_map_pkg::SRAM_BASE) begin
      sel = soc_map_pkg::SUB_SRAM;
    end else if ((req.adr & soc_map_pkg::REG_MASK) == soc_map_pkg::REG_BASE) begin
      sel = soc_map_pkg::SUB_REG;
    end else begin
      sel = soc_map_pkg::SUB_NONE;
    end
  end

  // all fields pass through, only vld is steered
  always_comb begin
    sram_req     = req;
    sram_req.vld = req.vld & (sel == soc_map_pkg::SUB_SRAM);
    reg_req      = req;
    reg_req.vld  = req.vld & (sel == soc_map_pkg::SUB_REG);
  end

  // ready of the addressed subordinate, unmapped never stalls
  always_comb begin
    case (sel)
      soc_map_pkg::SUB_SRAM: rdy = sram_rdy;
      soc_map_pkg::SUB_REG:  rdy = reg_rdy;
      default:               rdy = 1'b1;
    endcase
  end

  assign trn = req.vld & rdy;

  //////////////////////////////
  // select pipeline
  //////////////////////////////

  // idle cycles push SUB_NONE, so the output stays quiet
  always_ff @(posedge tcb) begin
    if (reset) begin
      for (int i = 0; i < DLY; i++) begin
        sel_pip[i].sel <= soc_map_pkg::SUB_NONE;
        sel_pip[i].nxe <= 1'b0;
      end
    end else begin
      sel_pip[0].sel <= trn ? sel : soc_map_pkg::SUB_NONE;
      sel_pip[0].nxe <= trn & (sel == soc_map_pkg::SUB_NONE);
      for (int i = 1; i < DLY; i++) begin
        sel_pip[i] <= sel_pip[i-1];
      end
    end
  end

  assign sel_out = sel_pip[DLY-1];

  // response merge, no register on this path
  always_comb begin
    case (sel_out.sel)
      soc_map_pkg::SUB_SRAM: rsp = sram_rsp;
      soc_map_pkg::SUB_REG:  rsp = reg_rsp;
      default: begin
        // error response for unmapped access
        rsp.vld = sel_out.nxe;
        rsp.rdt = '0;
        rsp.err = sel_out.nxe;
      end
    endcase
  end

endmodule : tcb_demux

/* src/soc_map_pkg.sv */
// address map of the subsystem
// a window matches when (adr & MASK) == BASE
// register offsets are byte offsets inside the register window

package soc_map_pkg;

  //////////////////////////////
  // windows
  //////////////////////////////

  // 4 KiB SRAM at the bottom of the map
  localparam logic [tcb_pkg::ABW-1:0] SRAM_BASE = 32'h0000_0000;
  localparam logic [tcb_pkg::ABW-1:0] SRAM_MASK = 32'hffff_f000;

  // 256 byte register block
  localparam logic [tcb_pkg::ABW-1:0] REG_BASE  = 32'h0001_0000;
  localparam logic [tcb_pkg::ABW-1:0] REG_MASK  = 32'hffff_ff00;

  //////////////////////////////
  // registers
  //////////////////////////////

  // offsets, compared against adr & ~REG_MASK
  localparam logic [tcb_pkg::ABW-1:0] REG_ID      = 32'h0000_0000;
  localparam logic [tcb_pkg::ABW-1:0] REG_SCRATCH = 32'h0000_0004;
  localparam logic [tcb_pkg::ABW-1:0] REG_COUNT   = 32'h0000_0008;

  // read-only identification value
  localparam logic [tcb_pkg::DBW-1:0] ID_VALUE = 32'h7cb0_0101;

  // demux select codes, zero means no subordinate
  localparam logic [1:0] SUB_NONE = 2'b00;
  localparam logic [1:0] SUB_SRAM = 2'b01;
  localparam logic [1:0] SUB_REG  = 2'b10;

endpackage : soc_map_pkg

/* src/tcb_pkg.sv */
// tightly coupled bus, shared widths and request/response types
// one word per transfer, byte enables cover DBW/8 bytes
// rsp.vld is a single-cycle strobe, the response path has no ready

package tcb_pkg;

  //////////////////////////////
  // widths
  //////////////////////////////

  // address width in bits
  localparam int unsigned ABW = 32;
  // data width in bits
  localparam int unsigned DBW = 32;
  // one enable per data byte
  localparam int unsigned BEW = DBW / 8;

  //////////////////////////////
  // request and response
  //////////////////////////////

  // request toward a subordinate, held stable while vld & ~rdy
  typedef struct packed {
    logic           vld;
    logic           wen;
    logic [ABW-1:0] adr;
    logic [BEW-1:0] ben;
    logic [DBW-1:0] wdt;
  } tcb_req_t;

  // response, DLY cycles after the transfer edge
  typedef struct packed {
    // high for exactly one cycle
    logic           vld;
    // read data, zero for writes
    logic [DBW-1:0] rdt;
    logic           err;
  } tcb_rsp_t;

endpackage : tcb_pkg
